// File: verilog/alu_cfg.svh
`ifndef ALU_CFG_SVH
`define ALU_CFG_SVH

// Operand and result word width
`define ALU_WIDTH 32

// Shift amount taken from the low bits of operand b
`define ALU_SHAMT_W 5

// One restoring step per quotient bit
`define DIV_CYCLES 32

`endif

// File: verilog/alu_pkg.sv
`default_nettype none

`include "alu_cfg.svh"

package alu_pkg;

    // Operation codes
    typedef enum logic [3:0] {
        op_add = 4'd0,
        op_sub = 4'd1,
        op_neg = 4'd2,
        op_or  = 4'd3,
        op_xor = 4'd4,
        op_and = 4'd5,
        op_not = 4'd6,
        op_mul = 4'd7,
        op_div = 4'd8,
        op_sll = 4'd9,
        op_srl = 4'd10,
        op_sra = 4'd11,
        op_ror = 4'd12,
        op_rol = 4'd13
    } alu_op_e;

    // Control FSM states, only the divide path leaves idle
    typedef enum logic [1:0] {
        st_idle     = 2'd0,
        st_div_run  = 2'd1,
        st_div_done = 2'd2
    } ctrl_state_e;

    typedef struct packed {
        alu_op_e               op;
        logic [`ALU_WIDTH-1:0] a;
        logic [`ALU_WIDTH-1:0] b;
    } alu_req_t;

    typedef struct packed {
        logic [`ALU_WIDTH-1:0] hi;
        logic [`ALU_WIDTH-1:0] lo;
        logic                  zero;
        logic                  neg;
        logic                  ovf;
    } alu_result_t;

    typedef struct packed {
        logic [`ALU_WIDTH-1:0] quotient;
        logic [`ALU_WIDTH-1:0] remainder;
    } div_result_t;

endpackage

`default_nettype wire

// File: verilog/alu_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module alu_ctrl (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              start,
    input  alu_pkg::alu_req_t req,
    input  logic              div_ready,
    output logic              busy,
    output logic              done,
    output logic              load,
    output logic              div_start,
    output alu_pkg::alu_req_t req_q
);

    alu_pkg::ctrl_state_e state_q;
    alu_pkg::ctrl_state_e state_d;
    logic                 accept;
    logic                 is_div;
    logic                 go_q;

    // Start is only taken while idle
    assign accept = start && !busy;
    assign is_div = (req.op == alu_pkg::op_div);

    always_comb begin
        state_d = state_q;
        case (state_q)
            alu_pkg::st_idle: begin
                if (accept && is_div) begin
                    state_d = alu_pkg::st_div_run;
                end
            end
            alu_pkg::st_div_run: begin
                if (div_ready) begin
                    state_d = alu_pkg::st_div_done;
                end
            end
            alu_pkg::st_div_done: begin
                state_d = alu_pkg::st_idle;
            end
            default: begin
                state_d = alu_pkg::st_idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q   <= alu_pkg::st_idle;
            go_q      <= 1'b0;
            div_start <= 1'b0;
            load      <= 1'b0;
            done      <= 1'b0;
            busy      <= 1'b0;
        end else begin
            state_q   <= state_d;
            // Single-cycle ops load one cycle after capture
            go_q      <= accept && !is_div;
            div_start <= accept && is_div;
            load      <= go_q || ((state_q == alu_pkg::st_div_run) && div_ready);
            // Lines up with the result register update
            done      <= load;
            if (accept) begin
                busy <= 1'b1;
            end else if (load) begin
                busy <= 1'b0;
            end
        end
    end

    // Latched request for core and divider
    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= req;
        end
    end

    a_no_start_while_busy: assert property (
        @(posedge clk) disable iff (!arst_n) busy |-> !start
    ) else $error("start asserted while busy");

    a_ready_only_in_run: assert property (
        @(posedge clk) disable iff (!arst_n) div_ready |-> (state_q == alu_pkg::st_div_run)
    ) else $error("div_ready outside divide run");

endmodule

`default_nettype wire

// File: verilog/cla_adder.sv
`timescale 1ns/100ps
`default_nettype none

`include "alu_cfg.svh"

module cla_adder (
    input  alu_pkg::alu_op_e      op,
    input  logic [`ALU_WIDTH-1:0] a,
    input  logic [`ALU_WIDTH-1:0] b,
    output logic [`ALU_WIDTH-1:0] sum,
    output logic                  ovf,
    output logic                  neg
);

    logic [`ALU_WIDTH-1:0]   x;
    logic [`ALU_WIDTH-1:0]   y;
    logic                    cin;
    logic [`ALU_WIDTH-1:0]   g;
    logic [`ALU_WIDTH-1:0]   p;
    logic [`ALU_WIDTH:0]     c;
    logic [`ALU_WIDTH/4-1:0] grp_g;
    logic [`ALU_WIDTH/4-1:0] grp_p;

    // Subtract is a + ~b + 1, negate is 0 + ~a + 1
    always_comb begin
        x   = a;
        y   = b;
        cin = 1'b0;
        case (op)
            alu_pkg::op_sub: begin
                y   = ~b;
                cin = 1'b1;
            end
            alu_pkg::op_neg: begin
                x   = '0;
                y   = ~a;
                cin = 1'b1;
            end
            default: begin
            end
        endcase
    end

    assign g = x & y;
    assign p = x ^ y;

    // Lookahead inside each nibble, group carries chained between nibbles
    always_comb begin
        c[0] = cin;
        for (int k = 0; k < `ALU_WIDTH/4; k++) begin
            c[4*k+1] = g[4*k] | (p[4*k] & c[4*k]);
            c[4*k+2] = g[4*k+1] | (p[4*k+1] & g[4*k])
                     | (p[4*k+1] & p[4*k] & c[4*k]);
            c[4*k+3] = g[4*k+2] | (p[4*k+2] & g[4*k+1])
                     | (p[4*k+2] & p[4*k+1] & g[4*k])
                     | (p[4*k+2] & p[4*k+1] & p[4*k] & c[4*k]);
            grp_g[k] = g[4*k+3] | (p[4*k+3] & g[4*k+2])
                     | (p[4*k+3] & p[4*k+2] & g[4*k+1])
                     | (p[4*k+3] & p[4*k+2] & p[4*k+1] & g[4*k]);
            grp_p[k] = &p[4*k +: 4];
            c[4*k+4] = grp_g[k] | (grp_p[k] & c[4*k]);
        end
    end

    assign sum = p ^ c[`ALU_WIDTH-1:0];
    // Signed overflow when carries into and out of the sign bit differ
    assign ovf = c[`ALU_WIDTH] ^ c[`ALU_WIDTH-1];
    assign neg = sum[`ALU_WIDTH-1];

endmodule

`default_nettype wire

// File: verilog/barrel_shifter.sv
`timescale 1ns/100ps
`default_nettype none

`include "alu_cfg.svh"

module barrel_shifter (
    input  alu_pkg::alu_op_e        op,
    input  logic [`ALU_WIDTH-1:0]   data,
    input  logic [`ALU_SHAMT_W-1:0] shamt,
    output logic [`ALU_WIDTH-1:0]   out
);

    logic                  left;
    logic                  rotate;
    logic                  fill_bit;
    logic [`ALU_WIDTH-1:0] stage;
    logic [`ALU_WIDTH-1:0] fill;

    function automatic logic [`ALU_WIDTH-1:0] reverse_bits(input logic [`ALU_WIDTH-1:0] v);
        logic [`ALU_WIDTH-1:0] r;
        for (int i = 0; i < `ALU_WIDTH; i++) begin
            r[i] = v[`ALU_WIDTH-1-i];
        end
        return r;
    endfunction

    // Left ops run through the right shifter on bit-reversed data
    assign left     = (op == alu_pkg::op_sll) || (op == alu_pkg::op_rol);
    assign rotate   = (op == alu_pkg::op_ror) || (op == alu_pkg::op_rol);
    assign fill_bit = (op == alu_pkg::op_sra) && data[`ALU_WIDTH-1];

    always_comb begin
        stage = left ? reverse_bits(data) : data;
        fill  = '0;
        for (int s = 0; s < `ALU_SHAMT_W; s++) begin
            if (shamt[s]) begin
                // Rotates wrap the stage onto itself
                fill  = rotate ? stage : {`ALU_WIDTH{fill_bit}};
                stage = (stage >> (1 << s)) | (fill << (`ALU_WIDTH - (1 << s)));
            end
        end
        out = left ? reverse_bits(stage) : stage;
    end

endmodule

`default_nettype wire

// File: verilog/seq_divider.sv
`timescale 1ns/100ps
`default_nettype none

`include "alu_cfg.svh"

module seq_divider (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  start,
    input  logic [`ALU_WIDTH-1:0] a,
    input  logic [`ALU_WIDTH-1:0] b,
    output logic                  ready,
    output alu_pkg::div_result_t  out
);

    logic                             run_q;
    logic                             fix_q;
    logic [$clog2(`DIV_CYCLES)-1:0]   cnt_q;
    logic [`ALU_WIDTH-1:0]            rem_q;
    logic [`ALU_WIDTH-1:0]            quo_q;
    logic [`ALU_WIDTH-1:0]            dvs_q;
    logic                             neg_quo_q;
    logic                             neg_rem_q;
    logic [`ALU_WIDTH-1:0]            a_mag;
    logic [`ALU_WIDTH-1:0]            b_mag;
    logic [`ALU_WIDTH:0]              partial;
    logic [`ALU_WIDTH:0]              diff;
    logic                             fits;

    assign a_mag = a[`ALU_WIDTH-1] ? -a : a;
    assign b_mag = b[`ALU_WIDTH-1] ? -b : b;

    // Restoring step, next dividend bit shifted into the remainder
    assign partial = {rem_q, quo_q[`ALU_WIDTH-1]};
    assign diff    = partial - {1'b0, dvs_q};
    assign fits    = (partial >= {1'b0, dvs_q});

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            run_q <= 1'b0;
            fix_q <= 1'b0;
            ready <= 1'b0;
            cnt_q <= '0;
        end else begin
            ready <= 1'b0;
            if (start) begin
                run_q <= 1'b1;
                cnt_q <= '0;
            end else if (run_q) begin
                cnt_q <= cnt_q + 1'b1;
                if (cnt_q == ($clog2(`DIV_CYCLES))'(`DIV_CYCLES - 1)) begin
                    run_q <= 1'b0;
                    fix_q <= 1'b1;
                end
            end else if (fix_q) begin
                fix_q <= 1'b0;
                ready <= 1'b1;
            end
        end
    end

    // Zero divisor needs no special case, every step fits
    always_ff @(posedge clk) begin
        if (start) begin
            rem_q     <= '0;
            quo_q     <= a_mag;
            dvs_q     <= b_mag;
            neg_quo_q <= a[`ALU_WIDTH-1] ^ b[`ALU_WIDTH-1];
            neg_rem_q <= a[`ALU_WIDTH-1];
        end else if (run_q) begin
            rem_q <= fits ? diff[`ALU_WIDTH-1:0] : partial[`ALU_WIDTH-1:0];
            quo_q <= {quo_q[`ALU_WIDTH-2:0], fits};
        end
    end

    // Sign fix-up, remainder follows the dividend
    always_ff @(posedge clk) begin
        if (fix_q) begin
            out.quotient  <= neg_quo_q ? -quo_q : quo_q;
            out.remainder <= neg_rem_q ? -rem_q : rem_q;
        end
    end

    a_no_start_while_running: assert property (
        @(posedge clk) disable iff (!arst_n) start |-> !(run_q || fix_q)
    ) else $error("divider restarted while running");

endmodule

`default_nettype wire

// File: verilog/alu_core.sv
`timescale 1ns/100ps
`default_nettype none

`include "alu_cfg.svh"

module alu_core (
    input  logic                 clk,
    input  logic                 arst_n,
    input  alu_pkg::alu_req_t    req,
    input  logic                 load,
    input  alu_pkg::div_result_t div_out,
    output alu_pkg::alu_result_t result
);

    logic [`ALU_WIDTH-1:0]   add_sum;
    logic                    add_ovf;
    logic                    add_neg;
    logic [`ALU_WIDTH-1:0]   sft_out;
    logic [2*`ALU_WIDTH-1:0] mul_out;
    alu_pkg::alu_result_t    result_d;

    cla_adder i_cla_adder (
        .op  (req.op),
        .a   (req.a),
        .b   (req.b),
        .sum (add_sum),
        .ovf (add_ovf),
        .neg (add_neg)
    );

    barrel_shifter i_barrel_shifter (
        .op    (req.op),
        .data  (req.a),
        .shamt (req.b[`ALU_SHAMT_W-1:0]),
        .out   (sft_out)
    );

    // Unsigned full-width product
    assign mul_out = {{`ALU_WIDTH{1'b0}}, req.a} * {{`ALU_WIDTH{1'b0}}, req.b};

    always_comb begin
        result_d.hi  = '0;
        result_d.lo  = '0;
        result_d.ovf = 1'b0;
        case (req.op)
            alu_pkg::op_add,
            alu_pkg::op_sub,
            alu_pkg::op_neg: begin
                result_d.lo  = add_sum;
                result_d.ovf = add_ovf;
            end
            alu_pkg::op_or:  result_d.lo = req.a | req.b;
            alu_pkg::op_xor: result_d.lo = req.a ^ req.b;
            alu_pkg::op_and: result_d.lo = req.a & req.b;
            alu_pkg::op_not: result_d.lo = ~req.a;
            alu_pkg::op_mul: begin
                result_d.hi = mul_out[2*`ALU_WIDTH-1:`ALU_WIDTH];
                result_d.lo = mul_out[`ALU_WIDTH-1:0];
            end
            // Quotient high, remainder low
            alu_pkg::op_div: begin
                result_d.hi = div_out.quotient;
                result_d.lo = div_out.remainder;
            end
            alu_pkg::op_sll,
            alu_pkg::op_srl,
            alu_pkg::op_sra,
            alu_pkg::op_ror,
            alu_pkg::op_rol: result_d.lo = sft_out;
            default: begin
            end
        endcase

        case (req.op)
            alu_pkg::op_add,
            alu_pkg::op_sub,
            alu_pkg::op_neg: result_d.neg = add_neg;
            alu_pkg::op_mul: result_d.neg = mul_out[2*`ALU_WIDTH-1];
            alu_pkg::op_div: result_d.neg = req.a[`ALU_WIDTH-1] ^ req.b[`ALU_WIDTH-1];
            default:         result_d.neg = result_d.lo[`ALU_WIDTH-1];
        endcase

        result_d.zero = ({result_d.hi, result_d.lo} == '0);
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            result <= '0;
        end else if (load) begin
            result <= result_d;
        end
    end

endmodule

`default_nettype wire

// File: verilog/alu_unit.sv
`timescale 1ns/100ps
`default_nettype none

module alu_unit (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 start,
    input  alu_pkg::alu_req_t    req,
    output logic                 busy,
    output logic                 done,
    output alu_pkg::alu_result_t result
);

    logic                 load;
    logic                 div_start;
    logic                 div_ready;
    alu_pkg::alu_req_t    req_q;
    alu_pkg::div_result_t div_out;

    alu_ctrl i_alu_ctrl (
        .clk       (clk),
        .arst_n    (arst_n),
        .start     (start),
        .req       (req),
        .div_ready (div_ready),
        .busy      (busy),
        .done      (done),
        .load      (load),
        .div_start (div_start),
        .req_q     (req_q)
    );

    // Divider sees the latched operands
    seq_divider i_seq_divider (
        .clk    (clk),
        .arst_n (arst_n),
        .start  (div_start),
        .a      (req_q.a),
        .b      (req_q.b),
        .ready  (div_ready),
        .out    (div_out)
    );

    alu_core i_alu_core (
        .clk     (clk),
        .arst_n  (arst_n),
        .req     (req_q),
        .load    (load),
        .div_out (div_out),
        .result  (result)
    );

endmodule

`default_nettype wire

// File: verification/tb_alu_unit.sv
`timescale 1ns/100ps
`default_nettype none

`include "alu_cfg.svh"

module tb_alu_unit;

    // Worst case per operation is 38 edges for a divide
    localparam int MAX_OPS        = 400;
    localparam int OP_CYCLES      = 40;
    localparam int TIMEOUT_CYCLES = MAX_OPS * OP_CYCLES;

    logic                 clk;
    logic                 arst_n;
    logic                 start;
    alu_pkg::alu_req_t    req;
    logic                 busy;
    logic                 done;
    alu_pkg::alu_result_t result;

    logic [31:0]          rng_state;
    int                   op_count;
    int                   cycle_count;
    int                   fail_count;

    alu_unit i_alu_unit (
        .clk    (clk),
        .arst_n (arst_n),
        .start  (start),
        .req    (req),
        .busy   (busy),
        .done   (done),
        .result (result)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    // Watchdog on the total run length
    initial begin
        cycle_count = 0;
        forever begin
            @(posedge clk);
            cycle_count++;
            if (cycle_count >= TIMEOUT_CYCLES) begin
                $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
                $display("Test failed");
                $fatal(1, "watchdog expired");
            end
        end
    end

    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // Mostly random words, a quarter of the time a corner value
    function automatic logic [31:0] rand_operand();
        logic [31:0] r;
        logic [31:0] sel;
        r = lcg_next();
        if (r[31:30] != 2'b00) begin
            return lcg_next();
        end
        sel = (lcg_next() >> 8) % 32'd5;
        case (sel)
            32'd0:   return 32'h0000_0000;
            32'd1:   return 32'h0000_0001;
            32'd2:   return 32'hFFFF_FFFF;
            32'd3:   return 32'h8000_0000;
            default: return 32'h7FFF_FFFF;
        endcase
    endfunction

    function automatic alu_pkg::alu_op_e rand_op();
        logic [31:0] sel;
        sel = (lcg_next() >> 8) % 32'd14;
        return alu_pkg::alu_op_e'(sel[3:0]);
    endfunction

    // Expected result straight from the result rules
    function automatic alu_pkg::alu_result_t model_result(input alu_pkg::alu_op_e op,
                                                         input logic [31:0] a,
                                                         input logic [31:0] b);
        alu_pkg::alu_result_t r;
        logic [63:0]          wide;
        logic [31:0]          a_mag;
        logic [31:0]          b_mag;
        logic [31:0]          q_mag;
        logic [31:0]          r_mag;
        logic [4:0]           sh;
        r     = '0;
        wide  = '0;
        sh    = b[4:0];
        a_mag = a[31] ? (32'd0 - a) : a;
        b_mag = b[31] ? (32'd0 - b) : b;
        case (op)
            alu_pkg::op_add: begin
                r.lo  = a + b;
                r.ovf = (a[31] == b[31]) && (r.lo[31] != a[31]);
            end
            alu_pkg::op_sub: begin
                r.lo  = a - b;
                r.ovf = (a[31] != b[31]) && (r.lo[31] != a[31]);
            end
            alu_pkg::op_neg: begin
                r.lo  = 32'd0 - a;
                r.ovf = a[31] && r.lo[31];
            end
            alu_pkg::op_or:  r.lo = a | b;
            alu_pkg::op_xor: r.lo = a ^ b;
            alu_pkg::op_and: r.lo = a & b;
            alu_pkg::op_not: r.lo = ~a;
            alu_pkg::op_mul: begin
                wide         = {32'd0, a} * {32'd0, b};
                {r.hi, r.lo} = wide;
            end
            alu_pkg::op_div: begin
                if (b_mag == 32'd0) begin
                    q_mag = 32'hFFFF_FFFF;
                    r_mag = a_mag;
                end else begin
                    q_mag = a_mag / b_mag;
                    r_mag = a_mag % b_mag;
                end
                r.hi = (a[31] ^ b[31]) ? (32'd0 - q_mag) : q_mag;
                r.lo = a[31] ? (32'd0 - r_mag) : r_mag;
            end
            alu_pkg::op_sll: r.lo = a << sh;
            alu_pkg::op_srl: r.lo = a >> sh;
            alu_pkg::op_sra: r.lo = $signed(a) >>> sh;
            alu_pkg::op_ror: begin
                wide = {a, a} >> sh;
                r.lo = wide[31:0];
            end
            alu_pkg::op_rol: begin
                wide = {a, a} << sh;
                r.lo = wide[63:32];
            end
            default: begin
            end
        endcase
        case (op)
            alu_pkg::op_mul: r.neg = wide[63];
            alu_pkg::op_div: r.neg = a[31] ^ b[31];
            default:         r.neg = r.lo[31];
        endcase
        r.zero = (r.hi == 32'd0) && (r.lo == 32'd0);
        return r;
    endfunction

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            fail_count++;
            $display("mismatch %s: got 0x%h, expected 0x%h", name, actual, expected);
            $display("Test failed");
            $fatal(1, "value check failed");
        end
    endtask

    // Entered and left 1 ns after a rising edge
    task automatic run_op(input alu_pkg::alu_op_e op, input logic [31:0] a,
                          input logic [31:0] b);
        alu_pkg::alu_result_t exp;
        int                   lat;
        int                   cycles;
        exp      = model_result(op, a, b);
        lat      = (op == alu_pkg::op_div) ? (`DIV_CYCLES + 4) : 2;
        start    = 1'b1;
        req.op   = op;
        req.a    = a;
        req.b    = b;
        @(posedge clk);
        #1;
        // Scrambled inputs must not reach the latched request
        start    = 1'b0;
        req.op   = alu_pkg::op_not;
        req.a    = ~a;
        req.b    = ~b;
        cycles   = 0;
        while (!done && cycles <= lat) begin
            check_value("busy", 64'(busy), 64'd1);
            @(posedge clk);
            #1;
            cycles++;
        end
        check_value("done", 64'(done), 64'd1);
        check_value("latency", 64'(cycles), 64'(lat));
        check_value("busy", 64'(busy), 64'd0);
        check_value("result.hi", 64'(result.hi), 64'(exp.hi));
        check_value("result.lo", 64'(result.lo), 64'(exp.lo));
        check_value("result.zero", 64'(result.zero), 64'(exp.zero));
        check_value("result.neg", 64'(result.neg), 64'(exp.neg));
        check_value("result.ovf", 64'(result.ovf), 64'(exp.ovf));
        @(posedge clk);
        #1;
        // One-cycle done, result held afterwards
        check_value("done", 64'(done), 64'd0);
        check_value("result.hi", 64'(result.hi), 64'(exp.hi));
        check_value("result.lo", 64'(result.lo), 64'(exp.lo));
        op_count++;
    endtask

    initial begin
        alu_pkg::alu_op_e op;
        logic [31:0]      a;
        logic [31:0]      b;
        arst_n     = 1'b0;
        start      = 1'b0;
        req        = '0;
        rng_state  = 32'd24;
        op_count   = 0;
        fail_count = 0;
        repeat (5) @(posedge clk);
        #1;
        arst_n = 1'b1;

        // Idle state after reset
        repeat (2) begin
            check_value("busy", 64'(busy), 64'd0);
            check_value("done", 64'(done), 64'd0);
            check_value("result.hi", 64'(result.hi), 64'd0);
            check_value("result.lo", 64'(result.lo), 64'd0);
            check_value("result.flags",
                        64'({result.zero, result.neg, result.ovf}), 64'd0);
            @(posedge clk);
            #1;
        end

        // Adder corners
        run_op(alu_pkg::op_add, 32'h7FFF_FFFF, 32'h0000_0001);
        run_op(alu_pkg::op_add, 32'h0000_0000, 32'h0000_0000);
        run_op(alu_pkg::op_add, 32'hFFFF_FFFF, 32'h0000_0001);
        run_op(alu_pkg::op_sub, 32'h8000_0000, 32'h0000_0001);
        run_op(alu_pkg::op_sub, 32'h0000_0005, 32'h0000_0005);
        run_op(alu_pkg::op_neg, 32'h8000_0000, 32'h0000_0000);
        run_op(alu_pkg::op_neg, 32'h0000_0000, 32'h1234_5678);
        run_op(alu_pkg::op_neg, 32'h0000_0001, 32'h0000_0000);

        // Logic
        run_op(alu_pkg::op_or,  32'hF0F0_0000, 32'h0000_0F0F);
        run_op(alu_pkg::op_xor, 32'hA5A5_A5A5, 32'hA5A5_A5A5);
        run_op(alu_pkg::op_and, 32'hFFFF_0000, 32'h8F0F_F0F0);
        run_op(alu_pkg::op_not, 32'hFFFF_FFFF, 32'h0000_0000);
        run_op(alu_pkg::op_not, 32'h0000_0000, 32'h0000_0000);

        // Shift amounts 0 and 31 for each shift op
        for (int k = 0; k < 5; k++) begin
            op = alu_pkg::alu_op_e'(4'(int'(alu_pkg::op_sll) + k));
            run_op(op, 32'h9ABC_DEF1, 32'hFFFF_FFE0);
            run_op(op, 32'h9ABC_DEF1, 32'h0000_001F);
        end

        // Multiply
        run_op(alu_pkg::op_mul, 32'hFFFF_FFFF, 32'hFFFF_FFFF);
        run_op(alu_pkg::op_mul, 32'h0001_0000, 32'h0001_0000);
        run_op(alu_pkg::op_mul, 32'h0000_0000, 32'hDEAD_BEEF);

        // Divide in all sign combinations and by zero
        run_op(alu_pkg::op_div, 32'd100, 32'd7);
        run_op(alu_pkg::op_div, 32'hFFFF_FF9C, 32'd7);
        run_op(alu_pkg::op_div, 32'd100, 32'hFFFF_FFF9);
        run_op(alu_pkg::op_div, 32'hFFFF_FF9C, 32'hFFFF_FFF9);
        run_op(alu_pkg::op_div, 32'd100, 32'd0);
        run_op(alu_pkg::op_div, 32'hFFFF_FF9C, 32'd0);
        run_op(alu_pkg::op_div, 32'h8000_0000, 32'hFFFF_FFFF);

        // Random mix for the rest
        while (op_count < MAX_OPS) begin
            op = rand_op();
            a  = rand_operand();
            b  = rand_operand();
            if (op == alu_pkg::op_div && lcg_next() > 32'h8000_0000) begin
                b = $signed(b) >>> 16;
            end
            run_op(op, a, b);
        end

        if (fail_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
+incdir+verilog
verilog/alu_pkg.sv
verilog/alu_ctrl.sv
verilog/cla_adder.sv
verilog/barrel_shifter.sv
verilog/seq_divider.sv
verilog/alu_core.sv
verilog/alu_unit.sv
verification/tb_alu_unit.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the ALU testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_alu_unit -f compile.f -o Vtb_alu_unit

# The log decides the outcome
obj_dir/Vtb_alu_unit > sim.log 2>&1 || true
cat sim.log

if grep -q "^Test passed$" sim.log; then
    exit 0
else
    exit 1
fi
